/* include/backend_cfg.svh */
// -------------------------------------------------------------------------
// back end sizing macros: data width, register index, link register, RAM depth
// -------------------------------------------------------------------------
`ifndef BACKEND_CFG_SVH
`define BACKEND_CFG_SVH

// data and address width
`define BE_XLEN 32

// register index width
`define BE_REG_BITS 5

// jump-and-link writes PC+4 here
`define BE_LINK_REG 31

// data RAM depth in words, word address is the low 8 bits of the word index
`define BE_DMEM_WORDS 256

`endif

/* verilog/backend_pkg.sv */
// -------------------------------------------------------------------------
// shared types: data word, register index, ALU function, access size, cause
// -------------------------------------------------------------------------
`default_nettype none

package backend_pkg;

    `include "backend_cfg.svh"

    typedef logic [`BE_XLEN-1:0] word_t;
    typedef logic [`BE_REG_BITS-1:0] reg_idx_t;

    // ALU function select, decoded upstream
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        NOR,
        SLL,
        SRL,
        SRA,
        LUI
    } alu_func_t;

    // memory access size, the unused code is treated as a word
    typedef enum logic [1:0] {
        WORD,
        HALF,
        BYTE
    } mem_size_t;

    // exception cause reported on the exception port
    typedef enum logic [2:0] {
        NONE       = 3'd0,
        OVERFLOW   = 3'd1,
        MISALIGNED = 3'd2
    } exc_cause_t;

endpackage

`default_nettype wire

/* verilog/alu.sv */
// -------------------------------------------------------------------------
// combinational ALU with signed overflow flag
// -------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  backend_pkg::word_t     i_a,
    input  backend_pkg::word_t     i_b,
    input  backend_pkg::alu_func_t i_func,
    output backend_pkg::word_t     o_result,
    output logic                   o_overflow
);
    import backend_pkg::*;

    localparam int MSB = $bits(word_t) - 1;

    word_t sum;
    word_t diff;

    assign sum  = i_a + i_b;
    assign diff = i_a - i_b;

    always_comb begin
        o_result   = sum;
        o_overflow = 1'b0;
        case (i_func)
            ADD: begin
                o_result   = sum;
                // same operand signs, result sign flipped
                o_overflow = (i_a[MSB] == i_b[MSB]) && (sum[MSB] != i_a[MSB]);
            end
            SUB: begin
                o_result   = diff;
                // operand signs differ, result takes the sign of b
                o_overflow = (i_a[MSB] != i_b[MSB]) && (diff[MSB] != i_a[MSB]);
            end
            AND: o_result = i_a & i_b;
            OR:  o_result = i_a | i_b;
            XOR: o_result = i_a ^ i_b;
            NOR: o_result = ~(i_a | i_b);
            // shifts move b by the low five bits of a
            SLL: o_result = i_b << i_a[4:0];
            SRL: o_result = i_b >> i_a[4:0];
            SRA: o_result = word_t'($signed(i_b) >>> i_a[4:0]);
            // low half of b into the upper half
            LUI: o_result = {i_b[15:0], 16'h0000};
            default: o_result = sum;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/exe_stage.sv */
// -------------------------------------------------------------------------
// EXE stage: ID/EXE register, operand select, compare, link, fault detection
// -------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "backend_cfg.svh"

module exe_stage (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_stall,
    input  logic                    i_issue,
    input  backend_pkg::word_t      i_pc,
    input  backend_pkg::word_t      i_da,
    input  backend_pkg::word_t      i_db,
    input  backend_pkg::word_t      i_imm,
    input  backend_pkg::reg_idx_t   i_target_reg,
    input  backend_pkg::alu_func_t  i_alu_func,
    input  logic                    i_alu_imm,
    input  logic                    i_shift_imm,
    input  logic                    i_link,
    input  logic                    i_slt,
    input  logic                    i_slt_sign,
    input  logic                    i_allow_ovf,
    input  logic                    i_reg_write,
    input  logic                    i_mem_read,
    input  logic                    i_mem_write,
    input  backend_pkg::mem_size_t  i_mem_size,
    input  logic                    i_load_sign,
    output logic                    o_valid,
    output backend_pkg::word_t      o_result,
    output backend_pkg::word_t      o_store_data,
    output backend_pkg::reg_idx_t   o_target_reg,
    output logic                    o_reg_write,
    output logic                    o_mem_read,
    output logic                    o_mem_write,
    output backend_pkg::mem_size_t  o_mem_size,
    output logic                    o_load_sign,
    output backend_pkg::exc_cause_t o_exc_cause,
    output backend_pkg::word_t      o_pc
);
    import backend_pkg::*;

    logic       r_valid;
    word_t      r_pc;
    word_t      r_da;
    word_t      r_db;
    word_t      r_imm;
    reg_idx_t   r_target_reg;
    alu_func_t  r_alu_func;
    logic       r_alu_imm;
    logic       r_shift_imm;
    logic       r_link;
    logic       r_slt;
    logic       r_slt_sign;
    logic       r_allow_ovf;
    logic       r_reg_write;
    logic       r_mem_read;
    logic       r_mem_write;
    mem_size_t  r_mem_size;
    logic       r_load_sign;

    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_result;
    logic       alu_ovf;
    logic       slt_bit;
    logic       misaligned;
    exc_cause_t cause;

    // valid bit, cleared by reset, frozen by stall
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_valid <= 1'b0;
        end else if (!i_stall) begin
            r_valid <= i_issue;
        end
    end

    // op payload, only meaningful while r_valid
    always_ff @(posedge clk) begin
        if (!i_stall) begin
            r_pc         <= i_pc;
            r_da         <= i_da;
            r_db         <= i_db;
            r_imm        <= i_imm;
            r_target_reg <= i_target_reg;
            r_alu_func   <= i_alu_func;
            r_alu_imm    <= i_alu_imm;
            r_shift_imm  <= i_shift_imm;
            r_link       <= i_link;
            r_slt        <= i_slt;
            r_slt_sign   <= i_slt_sign;
            r_allow_ovf  <= i_allow_ovf;
            r_reg_write  <= i_reg_write;
            r_mem_read   <= i_mem_read;
            r_mem_write  <= i_mem_write;
            r_mem_size   <= i_mem_size;
            r_load_sign  <= i_load_sign;
        end
    end

    // shift amount lives in imm[10:6]
    assign alu_a = r_shift_imm ? {{(`BE_XLEN-5){1'b0}}, r_imm[10:6]} : r_da;
    assign alu_b = r_alu_imm ? r_imm : r_db;

    alu alu_inst (
        .i_a        (alu_a),
        .i_b        (alu_b),
        .i_func     (r_alu_func),
        .o_result   (alu_result),
        .o_overflow (alu_ovf)
    );

    // set-less-than on the selected operands
    assign slt_bit = r_slt_sign ? ($signed(alu_a) < $signed(alu_b)) : (alu_a < alu_b);

    always_comb begin
        if (r_link) begin
            o_result = r_pc + word_t'(4);
        end else if (r_slt) begin
            o_result = {{(`BE_XLEN-1){1'b0}}, slt_bit};
        end else begin
            o_result = alu_result;
        end
    end

    // word needs offset 0, half needs an even offset
    assign misaligned = (r_mem_read || r_mem_write) &&
                        (((r_mem_size == WORD) && (o_result[1:0] != 2'b00)) ||
                         ((r_mem_size == HALF) && o_result[0]));

    always_comb begin
        if (r_allow_ovf && alu_ovf) begin
            cause = OVERFLOW;
        end else if (misaligned) begin
            cause = MISALIGNED;
        end else begin
            cause = NONE;
        end
    end

    // a faulting op goes on as an exception only
    assign o_valid     = r_valid && (cause == NONE);
    assign o_exc_cause = r_valid ? cause : NONE;

    assign o_target_reg = r_link ? reg_idx_t'(`BE_LINK_REG) : r_target_reg;
    assign o_store_data = r_db;
    assign o_reg_write  = r_reg_write;
    assign o_mem_read   = r_mem_read;
    assign o_mem_write  = r_mem_write;
    assign o_mem_size   = r_mem_size;
    assign o_load_sign  = r_load_sign;
    assign o_pc         = r_pc;

endmodule

`default_nettype wire

/* verilog/data_ram.sv */
// -------------------------------------------------------------------------
// data RAM with byte-enable write and registered read-before-write
// -------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "backend_cfg.svh"

module data_ram (
    input  logic                               clk,
    input  logic                               i_en,
    input  logic [$clog2(`BE_DMEM_WORDS)-1:0]  i_addr,
    input  logic                               i_we,
    input  logic [3:0]                         i_be,
    input  logic [`BE_XLEN-1:0]                i_wdata,
    output logic [`BE_XLEN-1:0]                o_rdata
);

    logic [`BE_XLEN-1:0] mem [`BE_DMEM_WORDS];

    // en low holds the read register and blocks the write
    always_ff @(posedge clk) begin
        if (i_en) begin
            // old word comes out, new bytes go in
            o_rdata <= mem[i_addr];
            if (i_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (i_be[b]) begin
                        mem[i_addr][8*b +: 8] <= i_wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_stage.sv */
// -------------------------------------------------------------------------
// MEM and WB stages: store steering, data RAM, load extraction, WB select
// -------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "backend_cfg.svh"

module mem_stage (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_stall,
    input  logic                    i_valid,
    input  backend_pkg::word_t      i_result,
    input  backend_pkg::word_t      i_store_data,
    input  backend_pkg::reg_idx_t   i_target_reg,
    input  logic                    i_reg_write,
    input  logic                    i_mem_read,
    input  logic                    i_mem_write,
    input  backend_pkg::mem_size_t  i_mem_size,
    input  logic                    i_load_sign,
    input  backend_pkg::exc_cause_t i_exc_cause,
    input  backend_pkg::word_t      i_pc,
    output logic                    o_wb_en,
    output backend_pkg::reg_idx_t   o_wb_reg,
    output backend_pkg::word_t      o_wb_data,
    output logic                    o_exc,
    output backend_pkg::exc_cause_t o_exc_cause,
    output backend_pkg::word_t      o_exc_pc
);
    import backend_pkg::*;

    localparam int unsigned RAM_AW = $clog2(`BE_DMEM_WORDS);

    logic [3:0] st_be;
    word_t      st_data;
    word_t      ram_rdata;

    logic       m_valid;
    exc_cause_t m_exc_cause;
    word_t      m_result;
    reg_idx_t   m_target_reg;
    logic       m_reg_write;
    logic       m_mem_read;
    mem_size_t  m_mem_size;
    logic       m_load_sign;
    word_t      m_pc;

    logic [4:0] ld_shift;
    word_t      ld_raw;
    word_t      ld_data;

    // big-endian lanes, offset k lands in byte lane 3-k
    always_comb begin
        case (i_mem_size)
            BYTE: begin
                st_be   = 4'b1000 >> i_result[1:0];
                st_data = {4{i_store_data[7:0]}};
            end
            HALF: begin
                st_be   = i_result[1] ? 4'b0011 : 4'b1100;
                st_data = {2{i_store_data[15:0]}};
            end
            default: begin
                st_be   = 4'b1111;
                st_data = i_store_data;
            end
        endcase
    end

    // store lands at the end of EXE, the load word is read on the same edge
    data_ram data_ram_inst (
        .clk     (clk),
        .i_en    (!i_stall),
        .i_addr  (i_result[2 +: RAM_AW]),
        .i_we    (i_valid && i_mem_write),
        .i_be    (st_be),
        .i_wdata (st_data),
        .o_rdata (ram_rdata)
    );

    // EXE/MEM control
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            m_valid     <= 1'b0;
            m_exc_cause <= NONE;
        end else if (!i_stall) begin
            m_valid     <= i_valid;
            m_exc_cause <= i_exc_cause;
        end
    end

    // EXE/MEM payload
    always_ff @(posedge clk) begin
        if (!i_stall) begin
            m_result     <= i_result;
            m_target_reg <= i_target_reg;
            m_reg_write  <= i_reg_write;
            m_mem_read   <= i_mem_read;
            m_mem_size   <= i_mem_size;
            m_load_sign  <= i_load_sign;
            m_pc         <= i_pc;
        end
    end

    // byte: 24,16,8,0 by offset; half: 16 at offset 0, 0 at offset 2
    always_comb begin
        case (m_mem_size)
            BYTE:    ld_shift = {~m_result[1:0], 3'b000};
            HALF:    ld_shift = {~m_result[1], 4'b0000};
            default: ld_shift = 5'd0;
        endcase
    end

    assign ld_raw = ram_rdata >> ld_shift;

    // mask down to size then zero or sign extend
    always_comb begin
        case (m_mem_size)
            BYTE:    ld_data = {{24{m_load_sign & ld_raw[7]}}, ld_raw[7:0]};
            HALF:    ld_data = {{16{m_load_sign & ld_raw[15]}}, ld_raw[15:0]};
            default: ld_data = ld_raw;
        endcase
    end

    // MEM/WB control, these are the output strobes
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_wb_en     <= 1'b0;
            o_exc       <= 1'b0;
            o_exc_cause <= NONE;
        end else if (!i_stall) begin
            o_wb_en     <= m_valid && m_reg_write;
            o_exc       <= (m_exc_cause != NONE);
            o_exc_cause <= m_exc_cause;
        end
    end

    // MEM/WB payload with write-back select
    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_wb_reg  <= m_target_reg;
            o_wb_data <= m_mem_read ? ld_data : m_result;
            o_exc_pc  <= m_pc;
        end
    end

endmodule

`default_nettype wire

/* verilog/backend_top.sv */
// -------------------------------------------------------------------------
// back end top: EXE stage feeding the MEM/WB stage
// -------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module backend_top (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_issue,
    input  logic                    i_stall,
    input  backend_pkg::word_t      i_pc,
    input  backend_pkg::word_t      i_da,
    input  backend_pkg::word_t      i_db,
    input  backend_pkg::word_t      i_imm,
    input  backend_pkg::reg_idx_t   i_target_reg,
    input  backend_pkg::alu_func_t  i_alu_func,
    input  logic                    i_alu_imm,
    input  logic                    i_shift_imm,
    input  logic                    i_link,
    input  logic                    i_slt,
    input  logic                    i_slt_sign,
    input  logic                    i_allow_ovf,
    input  logic                    i_reg_write,
    input  logic                    i_mem_read,
    input  logic                    i_mem_write,
    input  backend_pkg::mem_size_t  i_mem_size,
    input  logic                    i_load_sign,
    output logic                    o_wb_en,
    output backend_pkg::reg_idx_t   o_wb_reg,
    output backend_pkg::word_t      o_wb_data,
    output logic                    o_exc,
    output backend_pkg::exc_cause_t o_exc_cause,
    output backend_pkg::word_t      o_exc_pc
);
    import backend_pkg::*;

    // EXE to MEM, e_result doubles as the data address
    logic       e_valid;
    word_t      e_result;
    word_t      e_store_data;
    reg_idx_t   e_target_reg;
    logic       e_reg_write;
    logic       e_mem_read;
    logic       e_mem_write;
    mem_size_t  e_mem_size;
    logic       e_load_sign;
    exc_cause_t e_exc_cause;
    word_t      e_pc;

    exe_stage exe_stage_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_stall      (i_stall),
        .i_issue      (i_issue),
        .i_pc         (i_pc),
        .i_da         (i_da),
        .i_db         (i_db),
        .i_imm        (i_imm),
        .i_target_reg (i_target_reg),
        .i_alu_func   (i_alu_func),
        .i_alu_imm    (i_alu_imm),
        .i_shift_imm  (i_shift_imm),
        .i_link       (i_link),
        .i_slt        (i_slt),
        .i_slt_sign   (i_slt_sign),
        .i_allow_ovf  (i_allow_ovf),
        .i_reg_write  (i_reg_write),
        .i_mem_read   (i_mem_read),
        .i_mem_write  (i_mem_write),
        .i_mem_size   (i_mem_size),
        .i_load_sign  (i_load_sign),
        .o_valid      (e_valid),
        .o_result     (e_result),
        .o_store_data (e_store_data),
        .o_target_reg (e_target_reg),
        .o_reg_write  (e_reg_write),
        .o_mem_read   (e_mem_read),
        .o_mem_write  (e_mem_write),
        .o_mem_size   (e_mem_size),
        .o_load_sign  (e_load_sign),
        .o_exc_cause  (e_exc_cause),
        .o_pc         (e_pc)
    );

    mem_stage mem_stage_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_stall      (i_stall),
        .i_valid      (e_valid),
        .i_result     (e_result),
        .i_store_data (e_store_data),
        .i_target_reg (e_target_reg),
        .i_reg_write  (e_reg_write),
        .i_mem_read   (e_mem_read),
        .i_mem_write  (e_mem_write),
        .i_mem_size   (e_mem_size),
        .i_load_sign  (e_load_sign),
        .i_exc_cause  (e_exc_cause),
        .i_pc         (e_pc),
        .o_wb_en      (o_wb_en),
        .o_wb_reg     (o_wb_reg),
        .o_wb_data    (o_wb_data),
        .o_exc        (o_exc),
        .o_exc_cause  (o_exc_cause),
        .o_exc_pc     (o_exc_pc)
    );

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
// --------------------------------------------------------------------------
// free-running testbench clock
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic o_clk
);

    // starts low, first rising edge half a period in
    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

/* verification/tb_backend.sv */
// --------------------------------------------------------------------------
// testbench with op table, falling-edge driver, result monitor and summary
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "backend_cfg.svh"

module tb_backend;
    import backend_pkg::*;

    // flag bits of a table row
    localparam logic [11:0] F_AIMM = 12'h001;
    localparam logic [11:0] F_SIMM = 12'h002;
    localparam logic [11:0] F_LINK = 12'h004;
    localparam logic [11:0] F_SLT  = 12'h008;
    localparam logic [11:0] F_SSGN = 12'h010;
    localparam logic [11:0] F_OVF  = 12'h020;
    localparam logic [11:0] F_RW   = 12'h040;
    localparam logic [11:0] F_MR   = 12'h080;
    localparam logic [11:0] F_MW   = 12'h100;
    localparam logic [11:0] F_LSGN = 12'h200;
    localparam logic [11:0] F_HALF = 12'h400;
    localparam logic [11:0] F_BYTE = 12'h800;
    // address is da + imm for every memory op
    localparam logic [11:0] LOAD   = F_AIMM | F_RW | F_MR;
    localparam logic [11:0] STORE  = F_AIMM | F_MW;

    // one table row with stimulus and expected result
    typedef struct packed {
        logic        stall;
        word_t       pc;
        word_t       da;
        word_t       db;
        word_t       imm;
        reg_idx_t    rd;
        alu_func_t   func;
        logic [11:0] flags;
        word_t       exp_data;
        exc_cause_t  cause;
    } row_t;

    logic       clk;
    logic       i_rst_n;
    logic       i_issue;
    logic       i_stall;
    word_t      i_pc;
    word_t      i_da;
    word_t      i_db;
    word_t      i_imm;
    reg_idx_t   i_target_reg;
    alu_func_t  i_alu_func;
    logic       i_alu_imm;
    logic       i_shift_imm;
    logic       i_link;
    logic       i_slt;
    logic       i_slt_sign;
    logic       i_allow_ovf;
    logic       i_reg_write;
    logic       i_mem_read;
    logic       i_mem_write;
    mem_size_t  i_mem_size;
    logic       i_load_sign;
    logic       o_wb_en;
    reg_idx_t   o_wb_reg;
    word_t      o_wb_data;
    logic       o_exc;
    exc_cause_t o_exc_cause;
    word_t      o_exc_pc;

    row_t  rows[$];
    int    pend[$];
    int    err_count;
    int    checked;
    logic  timed_out;
    logic  edge_live;
    word_t next_pc;

    tb_clock #(.PERIOD_NS(40)) clock_inst (.o_clk(clk));

    backend_top backend_top_inst (.*);

    task automatic push_op(input alu_func_t func, input logic [11:0] flags, input word_t da,
                           input word_t db, input word_t imm, input reg_idx_t rd,
                           input word_t exp_data, input exc_cause_t cause);
        row_t r;
        r.stall    = 1'b0;
        r.pc       = next_pc;
        r.da       = da;
        r.db       = db;
        r.imm      = imm;
        r.rd       = rd;
        r.func     = func;
        r.flags    = flags;
        r.exp_data = exp_data;
        r.cause    = cause;
        rows.push_back(r);
        next_pc = next_pc + 32'd4;
    endtask

    // a stalled cycle that still offers an op which must not be taken
    task automatic insert_stall();
        row_t r;
        r.stall    = 1'b1;
        r.pc       = 32'hDEAD_0000;
        r.da       = 32'hDEAD_BEEF;
        r.db       = 32'h0000_0001;
        r.imm      = 32'h0;
        r.rd       = 5'd30;
        r.func     = ADD;
        r.flags    = F_RW;
        r.exp_data = 32'h0;
        r.cause    = NONE;
        rows.push_back(r);
    endtask

    task automatic drive_row(input row_t r);
        i_issue      = 1'b1;
        i_stall      = r.stall;
        i_pc         = r.pc;
        i_da         = r.da;
        i_db         = r.db;
        i_imm        = r.imm;
        i_target_reg = r.rd;
        i_alu_func   = r.func;
        i_alu_imm    = (r.flags & F_AIMM) != 0;
        i_shift_imm  = (r.flags & F_SIMM) != 0;
        i_link       = (r.flags & F_LINK) != 0;
        i_slt        = (r.flags & F_SLT) != 0;
        i_slt_sign   = (r.flags & F_SSGN) != 0;
        i_allow_ovf  = (r.flags & F_OVF) != 0;
        i_reg_write  = (r.flags & F_RW) != 0;
        i_mem_read   = (r.flags & F_MR) != 0;
        i_mem_write  = (r.flags & F_MW) != 0;
        i_load_sign  = (r.flags & F_LSGN) != 0;
        if ((r.flags & F_BYTE) != 0) begin
            i_mem_size = BYTE;
        end else if ((r.flags & F_HALF) != 0) begin
            i_mem_size = HALF;
        end else begin
            i_mem_size = WORD;
        end
    endtask

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    // oldest pending op against the outputs
    task automatic check_result();
        row_t     r;
        int       idx;
        int       errs_before;
        logic     exp_exc;
        logic     exp_en;
        reg_idx_t exp_reg;
        if (pend.size() == 0) begin
            $display("unexpected result at time %0t with no op pending", $time);
            err_count++;
        end else begin
            idx         = pend.pop_front();
            r           = rows[idx];
            errs_before = err_count;
            // a fault suppresses the write-back
            exp_exc = (r.cause != NONE);
            exp_en  = ((r.flags & F_RW) != 0) && !exp_exc;
            exp_reg = ((r.flags & F_LINK) != 0) ? reg_idx_t'(`BE_LINK_REG) : r.rd;
            compare("o_wb_en", 32'(o_wb_en), 32'(exp_en));
            compare("o_exc", 32'(o_exc), 32'(exp_exc));
            if (exp_en) begin
                compare("o_wb_reg", 32'(o_wb_reg), 32'(exp_reg));
                compare("o_wb_data", o_wb_data, r.exp_data);
            end
            if (exp_exc) begin
                compare("o_exc_cause", 32'(o_exc_cause), 32'(r.cause));
                compare("o_exc_pc", o_exc_pc, r.pc);
            end
            checked++;
            if (err_count == errs_before) begin
                $display("row %0d pc %h ok", idx, r.pc);
            end else begin
                $display("row %0d pc %h mismatch", idx, r.pc);
            end
        end
    endtask

    // stall level seen by the rising edge
    // outputs read on the falling edge
    always @(posedge clk) begin
        edge_live = i_rst_n && !i_stall;
        @(negedge clk);
        if (edge_live && (o_wb_en === 1'b1 || o_exc === 1'b1)) begin
            check_result();
        end
    end

    initial begin
        int wait_cycles;
        i_rst_n      = 1'b0;
        i_issue      = 1'b0;
        i_stall      = 1'b0;
        i_pc         = '0;
        i_da         = '0;
        i_db         = '0;
        i_imm        = '0;
        i_target_reg = '0;
        i_alu_func   = ADD;
        i_alu_imm    = 1'b0;
        i_shift_imm  = 1'b0;
        i_link       = 1'b0;
        i_slt        = 1'b0;
        i_slt_sign   = 1'b0;
        i_allow_ovf  = 1'b0;
        i_reg_write  = 1'b0;
        i_mem_read   = 1'b0;
        i_mem_write  = 1'b0;
        i_mem_size   = WORD;
        i_load_sign  = 1'b0;
        err_count    = 0;
        checked      = 0;
        timed_out    = 1'b0;
        edge_live    = 1'b0;
        next_pc      = 32'h0000_0100;

        // logic and arithmetic on register operands
        push_op(ADD, F_RW, 32'h0000_1234, 32'h0000_0F0F, 32'h0, 5'd1, 32'h0000_2143, NONE);
        push_op(SUB, F_RW, 32'h0000_1000, 32'h0000_0001, 32'h0, 5'd2, 32'h0000_0FFF, NONE);
        insert_stall();
        insert_stall();
        push_op(AND, F_RW, 32'hF0F0_1234, 32'h0FF0_FF00, 32'h0, 5'd3, 32'h00F0_1200, NONE);
        push_op(OR, F_RW, 32'hF0F0_1234, 32'h0FF0_FF00, 32'h0, 5'd4, 32'hFFF0_FF34, NONE);
        push_op(XOR, F_RW, 32'hF0F0_1234, 32'h0FF0_FF00, 32'h0, 5'd5, 32'hFF00_ED34, NONE);
        push_op(NOR, F_RW, 32'hF0F0_1234, 32'h0FF0_FF00, 32'h0, 5'd6, 32'h000F_00CB, NONE);
        // shift amount sits in imm[10:6] and da is ignored
        push_op(SLL, F_RW | F_SIMM, 32'h1F, 32'h8000_00F1, 32'h100, 5'd7, 32'h0000_0F10, NONE);
        push_op(SRL, F_RW | F_SIMM, 32'h1F, 32'h8000_1200, 32'h200, 5'd8, 32'h0080_0012, NONE);
        push_op(SRA, F_RW | F_SIMM, 32'h1F, 32'h8000_1200, 32'h200, 5'd9, 32'hFF80_0012, NONE);
        push_op(LUI, F_RW | F_AIMM, 32'h1234, 32'h0, 32'h0000_ABCD, 5'd10, 32'hABCD_0000, NONE);
        push_op(ADD, F_RW | F_AIMM, 32'h100, 32'h0, 32'hFFFF_FFF0, 5'd11, 32'h0000_00F0, NONE);
        // -1 against 1 signed and unsigned
        push_op(ADD, F_RW | F_SLT | F_SSGN, 32'hFFFF_FFFF, 32'h1, 32'h0, 5'd12, 32'h1, NONE);
        push_op(ADD, F_RW | F_SLT, 32'hFFFF_FFFF, 32'h1, 32'h0, 5'd13, 32'h0, NONE);
        insert_stall();
        // link writes pc+4 to r31
        next_pc = 32'h0000_0400;
        push_op(ADD, F_RW | F_LINK, 32'h0, 32'h0, 32'h0, 5'd5, 32'h0000_0404, NONE);
        push_op(ADD, F_RW | F_OVF, 32'h7FFF_FFFF, 32'h1, 32'h0, 5'd14, 32'h0, OVERFLOW);
        push_op(ADD, F_RW, 32'h7FFF_FFFF, 32'h1, 32'h0, 5'd14, 32'h8000_0000, NONE);
        push_op(SUB, F_RW | F_OVF, 32'h8000_0000, 32'h1, 32'h0, 5'd15, 32'h0, OVERFLOW);
        push_op(ADD, F_RW | F_OVF, 32'h5, 32'hFFFF_FFFE, 32'h0, 5'd15, 32'h3, NONE);

        // word A at 0x40 built from bytes and word B at 0x44 from halves
        push_op(ADD, STORE, 32'h40, 32'h1122_3344, 32'h0, 5'd0, 32'h0, NONE);
        push_op(ADD, STORE | F_BYTE, 32'h40, 32'h5555_5580, 32'h0, 5'd0, 32'h0, NONE);
        push_op(ADD, STORE | F_BYTE, 32'h40, 32'h5555_5512, 32'h1, 5'd0, 32'h0, NONE);
        insert_stall();
        push_op(ADD, STORE | F_BYTE, 32'h40, 32'h5555_55F3, 32'h2, 5'd0, 32'h0, NONE);
        push_op(ADD, STORE | F_BYTE, 32'h40, 32'h5555_5545, 32'h3, 5'd0, 32'h0, NONE);
        push_op(ADD, STORE, 32'h40, 32'h0BAD_F00D, 32'h4, 5'd0, 32'h0, NONE);
        push_op(ADD, STORE | F_HALF, 32'h40, 32'h1234_8765, 32'h4, 5'd0, 32'h0, NONE);
        push_op(ADD, STORE | F_HALF, 32'h40, 32'hAAAA_7ABC, 32'h6, 5'd0, 32'h0, NONE);
        // loads of every size
        // A is 8012F345 and B is 87657ABC
        push_op(ADD, LOAD, 32'h40, 32'h0, 32'h0, 5'd16, 32'h8012_F345, NONE);
        push_op(ADD, LOAD | F_BYTE | F_LSGN, 32'h40, 32'h0, 32'h0, 5'd17, 32'hFFFF_FF80, NONE);
        push_op(ADD, LOAD | F_BYTE, 32'h40, 32'h0, 32'h0, 5'd18, 32'h0000_0080, NONE);
        push_op(ADD, LOAD | F_BYTE | F_LSGN, 32'h40, 32'h0, 32'h1, 5'd19, 32'h0000_0012, NONE);
        push_op(ADD, LOAD | F_BYTE | F_LSGN, 32'h40, 32'h0, 32'h2, 5'd20, 32'hFFFF_FFF3, NONE);
        push_op(ADD, LOAD | F_BYTE, 32'h40, 32'h0, 32'h3, 5'd21, 32'h0000_0045, NONE);
        push_op(ADD, LOAD, 32'h40, 32'h0, 32'h4, 5'd22, 32'h8765_7ABC, NONE);
        // stall while the byte load of A waits in MEM and B is next to be read
        insert_stall();
        push_op(ADD, LOAD | F_HALF | F_LSGN, 32'h40, 32'h0, 32'h4, 5'd23, 32'hFFFF_8765, NONE);
        push_op(ADD, LOAD | F_HALF, 32'h40, 32'h0, 32'h4, 5'd24, 32'h0000_8765, NONE);
        push_op(ADD, LOAD | F_HALF | F_LSGN, 32'h40, 32'h0, 32'h6, 5'd25, 32'h0000_7ABC, NONE);
        push_op(ADD, LOAD | F_HALF, 32'h40, 32'h0, 32'h6, 5'd26, 32'h0000_7ABC, NONE);

        // misaligned accesses fault and leave both words alone
        next_pc = 32'h0000_0600;
        push_op(ADD, STORE, 32'h40, 32'hFFFF_FFFF, 32'h5, 5'd0, 32'h0, MISALIGNED);
        push_op(ADD, STORE | F_HALF, 32'h40, 32'h0, 32'h7, 5'd0, 32'h0, MISALIGNED);
        push_op(ADD, STORE, 32'h40, 32'h0, 32'h2, 5'd0, 32'h0, MISALIGNED);
        push_op(ADD, LOAD, 32'h40, 32'h0, 32'h2, 5'd27, 32'h0, MISALIGNED);
        push_op(ADD, LOAD | F_HALF | F_LSGN, 32'h40, 32'h0, 32'h1, 5'd28, 32'h0, MISALIGNED);
        push_op(ADD, LOAD, 32'h40, 32'h0, 32'h0, 5'd29, 32'h8012_F345, NONE);
        push_op(ADD, LOAD, 32'h40, 32'h0, 32'h4, 5'd30, 32'h8765_7ABC, NONE);

        // four rising edges in reset
        repeat (4) @(posedge clk);
        @(negedge clk);
        compare("o_wb_en after reset", 32'(o_wb_en), 32'd0);
        compare("o_exc after reset", 32'(o_exc), 32'd0);
        i_rst_n = 1'b1;

        // one row per cycle
        // ops with a visible result are queued
        for (int i = 0; i < rows.size(); i++) begin
            drive_row(rows[i]);
            if (!rows[i].stall && (((rows[i].flags & F_RW) != 0) || rows[i].cause != NONE)) begin
                pend.push_back(i);
            end
            @(negedge clk);
        end
        i_issue = 1'b0;
        i_stall = 1'b0;

        wait_cycles = 0;
        while (pend.size() != 0 && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (pend.size() != 0) begin
            $display("timeout: %0d ops never produced a result", pend.size());
            timed_out = 1'b1;
        end else begin
            // idle cycles so a stray result still shows
            repeat (3) @(negedge clk);
        end

        $display("ops checked %0d, errors %0d", checked, err_count);
        if (timed_out || err_count != 0) begin
            $display("Checks failed");
        end else begin
            $display("All checks passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
verilog/backend_pkg.sv
verilog/alu.sv
verilog/exe_stage.sv
verilog/data_ram.sv
verilog/mem_stage.sv
verilog/backend_top.sv
verification/tb_clock.sv
verification/tb_backend.sv

/* Makefile */
# Verilator build and run of the back end testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f tb.f --top-module tb_backend
	./obj_dir/Vtb_backend | tee $(LOG)
	@if grep -q "All checks passed" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
